// ==== hw/clkdiv_pkg.sv ====
package clkdiv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Divide value
    // 0 and 1 select bypass, N >= 2 gives a period of N input cycles
    typedef logic [7:0] clkdiv_div_t;

    // Reload request from the control FSM to the counter
    typedef struct packed {
        // Value to load into the counter
        clkdiv_div_t div;
        // Single-cycle reload strobe
        logic        load;
    } clkdiv_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // Defaults
    //////////////////////////////////////////////////////////////////////

    // Divide value after reset
    localparam clkdiv_div_t CLKDIV_DIV_INIT = 8'd0;

    // Counter starts in bypass after reset
    localparam logic CLKDIV_BYPASS_INIT = 1'b1;

    // Flop stages on every asynchronous input
    localparam int unsigned CLKDIV_SYNC_STAGES = 2;

endpackage

// ==== hw/clkdiv_rst_sync.sv ====
module clkdiv_rst_sync
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic test_mode_i,
    output logic s_rstn_sync
);

    // Two-stage release chain
    logic [1:0] rst_q;

    // Assert at once, release after two clock edges
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            rst_q <= 2'b00;
        end
        else
        begin
            rst_q <= {rst_q[0], 1'b1};
        end
    end

    // Test mode hands the pad reset straight to the design
    assign s_rstn_sync = test_mode_i ? rstn_i : rst_q[1];

endmodule

// ==== hw/clkdiv_sync_wedge.sv ====
module clkdiv_sync_wedge
(
    input  logic clk_i,
    input  logic s_rstn_sync,
    input  logic serial_i,
    output logic serial_o,
    output logic r_edge_o
);

    import clkdiv_pkg::*;

    // Synchroniser chain, bit 0 samples the async input
    logic [CLKDIV_SYNC_STAGES-1:0] sync_q;
    // Previous synchronised level for edge detection
    logic                          level_q;

    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
        begin
            sync_q  <= '0;
            level_q <= 1'b0;
        end
        else
        begin
            // Shift towards the MSB
            sync_q  <= {sync_q[CLKDIV_SYNC_STAGES-2:0], serial_i};
            level_q <= sync_q[CLKDIV_SYNC_STAGES-1];
        end
    end

    // Synchronised level doubles as the acknowledge
    assign serial_o = sync_q[CLKDIV_SYNC_STAGES-1];

    // One-cycle pulse in the first cycle the level is seen high
    assign r_edge_o = serial_o & ~level_q;

endmodule

// ==== hw/clkdiv_ctrl.sv ====
module clkdiv_ctrl
#(
    parameter clkdiv_pkg::clkdiv_div_t DIV_INIT = clkdiv_pkg::CLKDIV_DIV_INIT
)
(
    input  logic                    clk_i,
    input  logic                    s_rstn_sync,
    input  logic                    valid_pulse_i,
    input  clkdiv_pkg::clkdiv_div_t div_data_i,
    input  logic                    gate_async_i,
    output clkdiv_pkg::clkdiv_cfg_t cfg_o,
    output logic                    gate_en_o
);

    import clkdiv_pkg::*;

    typedef enum logic [1:0] {IDLE, STOP, WAIT, RELEASE} state_t;

    state_t                        state_q;
    state_t                        state_d;
    clkdiv_div_t                   div_q;
    logic [CLKDIV_SYNC_STAGES-1:0] gate_sync_q;
    logic                          clk_run;
    logic                          load;

    //////////////////////////////////////////////////////////////////////
    // Reconfiguration FSM
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Clock runs only while idle
        clk_run = 1'b0;
        load    = 1'b0;
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                clk_run = 1'b1;
                if (valid_pulse_i)
                    state_d = STOP;
            end
            STOP:
            begin
                // Gate is closed, reload the counter now
                load    = 1'b1;
                state_d = WAIT;
            end
            WAIT:
            begin
                state_d = RELEASE;
            end
            RELEASE:
            begin
                state_d = IDLE;
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    //////////////////////////////////////////////////////////////////////
    // Divide register and external gate
    //////////////////////////////////////////////////////////////////////

    // Sample data together with the pulse that moves IDLE to STOP
    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
            div_q <= DIV_INIT;
        else if (valid_pulse_i && state_q == IDLE)
            div_q <= div_data_i;
    end

    // Two-flop synchroniser for the external gate input
    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
            gate_sync_q <= '0;
        else
            gate_sync_q <= {gate_sync_q[CLKDIV_SYNC_STAGES-2:0], gate_async_i};
    end

    assign cfg_o.div  = div_q;
    assign cfg_o.load = load;

    // External gate can only hold the clock off, never force it on
    assign gate_en_o = clk_run & gate_sync_q[CLKDIV_SYNC_STAGES-1];

endmodule

// ==== hw/clkdiv_counter.sv ====
module clkdiv_counter
#(
    parameter clkdiv_pkg::clkdiv_div_t DIV_INIT    = clkdiv_pkg::CLKDIV_DIV_INIT,
    parameter logic                    BYPASS_INIT = clkdiv_pkg::CLKDIV_BYPASS_INIT
)
(
    input  logic                    clk_i,
    input  logic                    s_rstn_sync,
    input  logic                    test_mode_i,
    input  clkdiv_pkg::clkdiv_cfg_t cfg_i,
    output logic                    div_clk_o
);

    import clkdiv_pkg::*;

    // Active divide value
    clkdiv_div_t div_q;
    // Position inside the output period
    clkdiv_div_t cnt_q;
    clkdiv_div_t cnt_d;
    // Last count of the period and first count of the high phase
    clkdiv_div_t cnt_last;
    clkdiv_div_t cnt_half;
    logic        bypass_q;
    // Registered divided clock
    logic        clk_q;

    //////////////////////////////////////////////////////////////////////
    // Counter
    //////////////////////////////////////////////////////////////////////

    assign cnt_last = div_q - 8'd1;

    // floor(N/2) low counts, the remaining ceil(N/2) counts are high
    assign cnt_half = div_q >> 1;

    // Wrap at N-1
    always_comb
    begin
        if (cnt_q >= cnt_last)
            cnt_d = '0;
        else
            cnt_d = cnt_q + 8'd1;
    end

    always_ff @(posedge clk_i or negedge s_rstn_sync)
    begin
        if (!s_rstn_sync)
        begin
            div_q    <= DIV_INIT;
            bypass_q <= BYPASS_INIT;
            cnt_q    <= '0;
            clk_q    <= 1'b0;
        end
        else if (cfg_i.load)
        begin
            // New value arrives while the output gate is closed
            div_q    <= cfg_i.div;
            bypass_q <= (cfg_i.div < 8'd2);
            cnt_q    <= '0;
            // Count 0 always falls in the low phase
            clk_q    <= 1'b0;
        end
        else if (!bypass_q)
        begin
            cnt_q <= cnt_d;
            clk_q <= (cnt_d >= cnt_half);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output select
    //////////////////////////////////////////////////////////////////////

    // Bypass and test mode both hand out the source clock
    assign div_clk_o = (bypass_q | test_mode_i) ? clk_i : clk_q;

endmodule

// ==== hw/clkdiv_clock_gate.sv ====
module clkdiv_clock_gate
(
    input  logic clk_i,
    input  logic en_i,
    input  logic test_en_i,
    output logic clk_o
);

    // Enable held stable through the high phase
    logic en_latch;

    // Transparent while the clock is low
    always_latch
    begin
        if (!clk_i)
            en_latch = en_i | test_en_i;
    end

    // Enable never changes while clk_i is high, so no glitch reaches the output
    assign clk_o = clk_i & en_latch;

endmodule

// ==== hw/clock_divider.sv ====
module clock_divider
#(
    parameter clkdiv_pkg::clkdiv_div_t DIV_INIT    = clkdiv_pkg::CLKDIV_DIV_INIT,
    parameter logic                    BYPASS_INIT = clkdiv_pkg::CLKDIV_BYPASS_INIT
)
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    test_mode_i,
    input  logic                    clk_gate_async_i,
    input  clkdiv_pkg::clkdiv_div_t clk_div_data_i,
    input  logic                    clk_div_valid_i,
    output logic                    clk_div_ack_o,
    output logic                    clk_o
);

    import clkdiv_pkg::*;

    logic        s_rstn_sync;
    logic        valid_pulse;
    clkdiv_cfg_t cfg;
    logic        gate_en;
    logic        div_clk;

    // Reset release aligned to clk_i
    clkdiv_rst_sync i_rst_sync
    (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .test_mode_i ( test_mode_i ),
        .s_rstn_sync ( s_rstn_sync )
    );

    // Async valid in, acknowledge and load pulse out
    clkdiv_sync_wedge i_sync_wedge
    (
        .clk_i       ( clk_i           ),
        .s_rstn_sync ( s_rstn_sync     ),
        .serial_i    ( clk_div_valid_i ),
        .serial_o    ( clk_div_ack_o   ),
        .r_edge_o    ( valid_pulse     )
    );

    clkdiv_ctrl
    #(
        .DIV_INIT ( DIV_INIT )
    )
    i_ctrl
    (
        .clk_i         ( clk_i            ),
        .s_rstn_sync   ( s_rstn_sync      ),
        .valid_pulse_i ( valid_pulse      ),
        .div_data_i    ( clk_div_data_i   ),
        .gate_async_i  ( clk_gate_async_i ),
        .cfg_o         ( cfg              ),
        .gate_en_o     ( gate_en          )
    );

    clkdiv_counter
    #(
        .DIV_INIT    ( DIV_INIT    ),
        .BYPASS_INIT ( BYPASS_INIT )
    )
    i_counter
    (
        .clk_i       ( clk_i       ),
        .s_rstn_sync ( s_rstn_sync ),
        .test_mode_i ( test_mode_i ),
        .cfg_i       ( cfg         ),
        .div_clk_o   ( div_clk     )
    );

    // Final gate on the divided clock
    clkdiv_clock_gate i_clock_gate
    (
        .clk_i     ( div_clk     ),
        .en_i      ( gate_en     ),
        .test_en_i ( test_mode_i ),
        .clk_o     ( clk_o       )
    );

endmodule

// ==== bench/tb_clock_divider.sv ====
module tb_clock_divider;

    timeunit 1ns;
    timeprecision 1ps;

    import clkdiv_pkg::*;

    localparam int TIMEOUT = 200;

    logic        clk_i;
    logic        rstn_i;
    logic        test_mode_i;
    logic        clk_gate_async_i;
    clkdiv_div_t clk_div_data_i;
    logic        clk_div_valid_i;
    logic        clk_div_ack_o;
    logic        clk_o;

    logic [31:0] lfsr;
    clkdiv_div_t div;
    int          errors = 0;
    int          checks = 0;
    // Monitor state, one count per clk_i cycle
    int          rises = 0;
    int          period = 0;
    int          high = 0;
    int          cyc = 0;
    int          hi_cnt = 0;
    logic        prev = 1'b0;

    clock_divider i_clock_divider
    (
        .clk_i            ( clk_i            ),
        .rstn_i           ( rstn_i           ),
        .test_mode_i      ( test_mode_i      ),
        .clk_gate_async_i ( clk_gate_async_i ),
        .clk_div_data_i   ( clk_div_data_i   ),
        .clk_div_valid_i  ( clk_div_valid_i  ),
        .clk_div_ack_o    ( clk_div_ack_o    ),
        .clk_o            ( clk_o            )
    );

    // 40 ns source clock
    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Period monitor
    //////////////////////////////////////////////////////////////////////

    // Samples mid high and mid low phase, a rise always lands on a high sample
    always
    begin
        @(posedge clk_i);
        #10;
        if (prev == 1'b0 && clk_o == 1'b1)
        begin
            period = cyc;
            high   = hi_cnt;
            rises++;
            cyc    = 0;
            hi_cnt = 0;
        end
        cyc++;
        if (clk_o == 1'b1)
            hi_cnt++;
        @(negedge clk_i);
        #10;
        prev = clk_o;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int expected_period(input clkdiv_div_t n);
        return (n < 8'd2) ? 1 : int'(n);
    endfunction

    // Bypass counts as one high sample per period
    function automatic int expected_high(input clkdiv_div_t n);
        return (n < 8'd2) ? 1 : (int'(n) + 1) / 2;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // Polled at the falling edge, DUT outputs move on the rising edge
    task automatic wait_level(input string what, input bit use_ack, input logic level);
        int cycles;
        cycles = 0;
        while ((use_ack ? clk_div_ack_o : clk_o) !== level && cycles < TIMEOUT)
        begin
            @(negedge clk_i);
            cycles++;
        end
        if ((use_ack ? clk_div_ack_o : clk_o) !== level)
        begin
            errors++;
            $display("Timeout, %s never went to %0b", what, level);
        end
    endtask

    task automatic wait_rise();
        int start;
        int cycles;
        start  = rises;
        cycles = 0;
        while (rises == start && cycles < TIMEOUT)
        begin
            @(negedge clk_i);
            cycles++;
        end
        if (rises == start)
        begin
            errors++;
            $display("Timeout, clk_o never rose");
        end
    endtask

    // Four-phase handshake on the config port
    task automatic program_div(input clkdiv_div_t n);
        @(negedge clk_i);
        check("ack idle", 0, int'(clk_div_ack_o));
        clk_div_data_i  = n;
        clk_div_valid_i = 1'b1;
        wait_level("clk_div_ack_o", 1'b1, 1'b1);
        clk_div_valid_i = 1'b0;
        wait_level("clk_div_ack_o", 1'b1, 1'b0);
    endtask

    // First two rises still span the reload gap
    task automatic measure_periods(input string name, input clkdiv_div_t n);
        repeat (2) wait_rise();
        repeat (4)
        begin
            wait_rise();
            check({name, " period"}, expected_period(n), period);
            check({name, " high"}, expected_high(n), high);
        end
    endtask

    // clk_o must equal clk_i in both phases
    task automatic follow_check(input string name, input int n);
        repeat (n)
        begin
            @(posedge clk_i);
            #10;
            check(name, 1, int'(clk_o));
            @(negedge clk_i);
            #10;
            check(name, 0, int'(clk_o));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and compare
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rstn_i           = 1'b0;
        test_mode_i      = 1'b0;
        clk_gate_async_i = 1'b1;
        clk_div_data_i   = '0;
        clk_div_valid_i  = 1'b0;
        lfsr             = 32'h13c4_83d1;
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;

        // Bypass straight out of reset
        repeat (2) wait_rise();
        follow_check("reset bypass", 16);

        // Random divide values 2..17, four LFSR bits each
        repeat (8)
        begin
            div = '0;
            for (int b = 0; b < 4; b++)
            begin
                lfsr = lfsr_step(lfsr);
                div  = {div[6:0], lfsr[0]};
            end
            div = div + 8'd2;
            program_div(div);
            measure_periods($sformatf("divide %0d", div), div);
        end

        // Both bypass codes
        program_div(8'd0);
        repeat (2) wait_rise();
        follow_check("bypass 0", 8);
        program_div(8'd1);
        repeat (2) wait_rise();
        follow_check("bypass 1", 8);

        // External gate holds a divided clock low
        program_div(8'd6);
        measure_periods("gate before", 8'd6);
        @(negedge clk_i);
        clk_gate_async_i = 1'b0;
        repeat (2) @(negedge clk_i);
        wait_level("clk_o", 1'b0, 1'b0);
        repeat (50)
        begin
            @(posedge clk_i);
            #10;
            check("gate low", 0, int'(clk_o));
        end
        @(negedge clk_i);
        clk_gate_async_i = 1'b1;
        measure_periods("gate release", 8'd6);

        // Test mode overrides both gate and divider
        @(negedge clk_i);
        clk_gate_async_i = 1'b0;
        test_mode_i      = 1'b1;
        repeat (2) wait_rise();
        follow_check("test mode", 16);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== sim.f ====
hw/clkdiv_pkg.sv
hw/clkdiv_rst_sync.sv
hw/clkdiv_sync_wedge.sv
hw/clkdiv_ctrl.sv
hw/clkdiv_counter.sv
hw/clkdiv_clock_gate.sv
hw/clock_divider.sv
bench/tb_clock_divider.sv

// ==== Makefile ====
SHELL     := /bin/bash
VERILATOR := verilator
FLAGS     := --timing
TOP       := tb_clock_divider
FILELIST  := sim.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	set -o pipefail; ./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failures"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
